// ==== Makefile ====
# Verilator build and run of the free list testbench
BIN := obj_dir/Vtb_prf_freelist

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): flist.f $(wildcard verilog/*.sv bench/*.sv)
	verilator --binary --timing --assert -sv --top-module tb_prf_freelist -f flist.f

clean:
	rm -rf obj_dir

// ==== bench/freelist_stimulus.txt ====
# columns: test op group spec first_prf count, all decimal
# alloc expects count registers from first_prf up; release frees them; idle waits count cycles
fill     alloc    3 0 32  3
release  release  0 0  5  2
release  alloc    1 0 35 29
release  alloc    1 0  5  2
release  release  0 0 32 12
commit   open     7 0  0  0
commit   alloc    7 1 32  3
commit   commit   7 0  0  0
commit   alloc    2 0 35  2
abandon  open     9 0  0  0
abandon  alloc    9 1 37  4
abandon  abandon  9 0  0  0
abandon  alloc    4 0 41  3
abandon  alloc    4 0 37  4
bp       release  0 0 44  8
bp       open     5 0  0  0
bp       alloc    5 1 44  4
bp       alloc    5 0 48  4
bp       commit   5 0  0  0
idle     idle     0 0  0 10

// ==== bench/tb_prf_freelist.sv ====
/* Testbench for prf_freelist_top, run from the project root so the stimulus path resolves.
   Group commands are sent only after every earlier response is back; rsp_ready is random.
   Speculative requests for unknown groups are not exercised, as they give no response. */
`timescale 1ns/1ns
`default_nettype none

module tb_prf_freelist;

    import rename_types_pkg::*;
    import rename_chan_pkg::*;

    localparam logic [31:0] SEED = 32'h9099_3bd6;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    alloc_req_t req;
    logic       cmd_valid;
    logic       cmd_ready;
    group_cmd_t cmd;
    logic       rel_valid;
    logic       rel_ready;
    prf_t       rel_prf;
    logic       rsp_valid;
    logic       rsp_ready;
    alloc_rsp_t rsp;

    // Responses still owed, oldest first, with the test that asked for each
    alloc_rsp_t exp_q [$];
    string      exp_name_q [$];

    // One entry per stimulus line
    string      name_list [$];
    string      op_list [$];
    int         fgr_list [$];
    int         spec_list [$];
    int         prf_list [$];
    int         cnt_list [$];

    int         cycles;
    int         cycle_limit;

    prf_freelist_top #(
        .NUM_BANKS (4)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rel_valid (rel_valid),
        .rel_ready (rel_ready),
        .rel_prf   (rel_prf),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic wait_responses_drained();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_alloc(input string name, input int fgr, input int spec, input int prf);
        alloc_rsp_t exp;
        req_valid = 1'b1;
        req.fgr   = fgr_t'(fgr);
        req.spec  = (spec != 0);
        while (!req_ready)
            @(negedge clk);
        exp.prf = prf_t'(prf);
        exp.fgr = fgr_t'(fgr);
        exp_q.push_back(exp);
        exp_name_q.push_back(name);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_release(input int prf);
        rel_valid = 1'b1;
        rel_prf   = prf_t'(prf);
        while (!rel_ready)
            @(negedge clk);
        @(negedge clk);
        rel_valid = 1'b0;
    endtask

    task automatic send_group_cmd(input group_op_t op, input int fgr);
        wait_responses_drained();
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.fgr   = fgr_t'(fgr);
        while (!cmd_ready)
            @(negedge clk);
        @(negedge clk);
        cmd_valid = 1'b0;
        // Slot frees once the core has acted, after the drain for abandon
        while (!cmd_ready)
            @(negedge clk);
    endtask

    task automatic check_idle(input string name, input int n);
        wait_responses_drained();
        repeat (n) begin
            @(negedge clk);
            assert (!rsp_valid)
                else abort_run($sformatf("error %s: expected rsp_valid 0, actual 1", name));
            assert (req_ready && cmd_ready && rel_ready)
                else abort_run($sformatf("error %s: expected readies 111, actual %b%b%b",
                                         name, req_ready, cmd_ready, rel_ready));
        end
    endtask

    // Back-pressure and response checking share one falling-edge process
    initial begin
        alloc_rsp_t exp;
        string      name;
        cycles    = 0;
        rsp_ready = 1'b1;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            cycles++;
            assert (cycles <= cycle_limit)
                else abort_run($sformatf("timeout after %0d cycles", cycles));
            // Roughly one stalled cycle in four
            rsp_ready = ($urandom % 4) != 0;
            if (!rst && rsp_valid && rsp_ready) begin
                assert (exp_q.size() != 0) begin
                    exp  = exp_q.pop_front();
                    name = exp_name_q.pop_front();
                    assert (rsp == exp)
                        else abort_run($sformatf(
                            "error %s: expected prf %0d fgr %0d, actual prf %0d fgr %0d",
                            name, exp.prf, exp.fgr, rsp.prf, rsp.fgr));
                end else begin
                    abort_run("a response arrived while no allocation was outstanding");
                end
            end
        end
    end

    initial begin
        int    fd;
        int    got;
        int    i;
        int    k;
        string line;
        string name;
        string op;
        int    fgr;
        int    spec;
        int    prf;
        int    cnt;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rel_valid   = 1'b0;
        rel_prf     = '0;
        cycle_limit = 40;

        fd = $fopen("bench/freelist_stimulus.txt", "r");
        if (fd == 0)
            abort_run("cannot open bench/freelist_stimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && line.len() > 0 && line[0] != "#") begin
                got = $sscanf(line, "%s %s %d %d %d %d", name, op, fgr, spec, prf, cnt);
                if (got == 6) begin
                    name_list.push_back(name);
                    op_list.push_back(op);
                    fgr_list.push_back(fgr);
                    spec_list.push_back(spec);
                    prf_list.push_back(prf);
                    cnt_list.push_back(cnt);
                end else if (got > 0) begin
                    abort_run($sformatf("malformed stimulus line: %s", line));
                end
            end
        end
        $fclose(fd);
        cycle_limit = 40 + 20 * op_list.size();

        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < op_list.size(); i++) begin
            name = name_list[i];
            op   = op_list[i];
            fgr  = fgr_list[i];
            spec = spec_list[i];
            prf  = prf_list[i];
            cnt  = cnt_list[i];
            if (op == "alloc") begin
                for (k = 0; k < cnt; k++)
                    send_alloc(name, fgr, spec, prf + k);
            end else if (op == "release") begin
                for (k = 0; k < cnt; k++)
                    send_release(prf + k);
            end else if (op == "open") begin
                send_group_cmd(GRP_OPEN, fgr);
            end else if (op == "commit") begin
                send_group_cmd(GRP_COMMIT, fgr);
            end else if (op == "abandon") begin
                send_group_cmd(GRP_ABANDON, fgr);
            end else if (op == "idle") begin
                check_idle(name, cnt);
            end else begin
                abort_run($sformatf("unknown stimulus operation %s", op));
            end
        end

        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected responses never arrived", exp_q.size()));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/rename_types_pkg.sv
verilog/rename_chan_pkg.sv
verilog/common_fifo_ram_1w1r.sv
verilog/freelist_checkpoint_bank.sv
verilog/rename_req_front.sv
verilog/freelist_core.sv
verilog/alloc_rsp_buffer.sv
verilog/prf_freelist_top.sv
bench/tb_prf_freelist.sv

// ==== verilog/alloc_rsp_buffer.sv ====
/* Output side: two-entry in-order response buffer with registered outputs.
   core_rsp_ready promises room for a response issued by the core this cycle. */
`timescale 1ns/1ns
`default_nettype none

module alloc_rsp_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        core_rsp_valid,
    output logic                        core_rsp_ready,
    input  rename_chan_pkg::alloc_rsp_t core_rsp,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output rename_chan_pkg::alloc_rsp_t rsp
);

    import rename_chan_pkg::*;

    logic [1:0] cnt_q;
    logic [2:0] level;
    logic       pop;
    alloc_rsp_t slot1_q;

    assign rsp_valid = (cnt_q != 2'd0);
    assign pop       = rsp_valid && rsp_ready;

    // Entries held after this cycle, counting the one already in flight
    assign level          = 3'(cnt_q) + 3'(core_rsp_valid) - 3'(pop);
    assign core_rsp_ready = (level < 3'd2);

    always_ff @(posedge clk) begin
        if (rst)
            cnt_q <= 2'd0;
        else
            cnt_q <= cnt_q + 2'(core_rsp_valid) - 2'(pop);
    end

    always_ff @(posedge clk) begin
        if (core_rsp_valid && (cnt_q == 2'd0 || (cnt_q == 2'd1 && pop)))
            rsp <= core_rsp;
        else if (pop)
            rsp <= slot1_q;
        if (core_rsp_valid)
            slot1_q <= core_rsp;
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        core_rsp_valid |-> (cnt_q != 2'd2) || pop)
        else $error("core issued a response without buffer room");

endmodule

`default_nettype wire

// ==== verilog/common_fifo_ram_1w1r.sv ====
/* RAM FIFO, one write and one read port; dout shows the head entry.
   Writes when full and reads when empty are ignored. clear empties it like rst. */
`timescale 1ns/1ns
`default_nettype none

module common_fifo_ram_1w1r #(
    parameter int DEPTH_LOG2 = 2,
    parameter int WIDTH      = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic [WIDTH-1:0] din,
    input  logic             wen,
    input  logic             ren,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]    mem [DEPTH];
    // Extra pointer bit tells full from empty
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                do_wr;
    logic                do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                   (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    assign do_wr = wen && !full;
    assign do_rd = ren && !empty;
    assign dout  = mem[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
    end

endmodule

`default_nettype wire

// ==== verilog/freelist_checkpoint_bank.sv ====
/* One checkpoint bank with valid, abandoned and group tag, plus up to four recorded
   registers in allocation order. fifo_clear empties the record list only. */
`timescale 1ns/1ns
`default_nettype none

module freelist_checkpoint_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tag_wen,
    input  logic                   tag_valid_in,
    input  logic                   tag_abandoned_in,
    output logic                   tag_valid,
    output logic                   tag_abandoned,
    input  logic                   fgr_wen,
    input  rename_types_pkg::fgr_t fgr_in,
    output rename_types_pkg::fgr_t fgr,
    input  logic                   fifo_clear,
    input  logic                   push,
    input  rename_types_pkg::prf_t push_prf,
    input  logic                   pop,
    output rename_types_pkg::prf_t pop_prf,
    output logic                   full,
    output logic                   empty
);

    import rename_types_pkg::*;

    localparam int BANK_DEPTH_LOG2 = 2;

    // Both flags are written together
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_valid     <= 1'b0;
            tag_abandoned <= 1'b0;
        end else if (tag_wen) begin
            tag_valid     <= tag_valid_in;
            tag_abandoned <= tag_abandoned_in;
        end
    end

    // Group tag loaded when the bank opens
    always_ff @(posedge clk) begin
        if (fgr_wen)
            fgr <= fgr_in;
    end

    common_fifo_ram_1w1r #(
        .DEPTH_LOG2 (BANK_DEPTH_LOG2),
        .WIDTH      ($bits(prf_t))
    ) u_rec_fifo (
        .clk   (clk),
        .rst   (rst),
        .clear (fifo_clear),
        .din   (push_prf),
        .wen   (push),
        .ren   (pop),
        .dout  (pop_prf),
        .full  (full),
        .empty (empty)
    );

    // Core must check room before recording and only drain what exists
    a_bank_flow: assert property (@(posedge clk) disable iff (rst)
        !(push && full) && !(pop && empty))
        else $error("checkpoint bank overflow or underflow");

endmodule

`default_nettype wire

// ==== verilog/freelist_core.sv ====
/* Free list core with reset fill of registers NUM_ARCH..63, FIFO free list and banks.
   Abandon holds fe_cmd_ready low until its bank has drained back. */
`timescale 1ns/1ns
`default_nettype none

module freelist_core #(
    parameter int NUM_BANKS = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fe_req_valid,
    output logic                        fe_req_ready,
    input  rename_chan_pkg::alloc_req_t fe_req,
    input  logic                        fe_cmd_valid,
    output logic                        fe_cmd_ready,
    input  rename_chan_pkg::group_cmd_t fe_cmd,
    input  logic                        rel_valid,
    output logic                        rel_ready,
    input  rename_types_pkg::prf_t      rel_prf,
    output logic                        core_rsp_valid,
    input  logic                        core_rsp_ready,
    output rename_chan_pkg::alloc_rsp_t core_rsp
);

    import rename_types_pkg::*;
    import rename_chan_pkg::*;

    typedef enum logic [1:0] {ST_FILL, ST_RUN, ST_DRAIN} state_t;

    state_t               state_q;
    prf_t                 fill_prf_q;
    logic [NUM_BANKS-1:0] drain_sel_q;

    logic fl_wen;
    logic fl_ren;
    logic fl_full;
    logic fl_empty;
    prf_t fl_din;
    prf_t fl_dout;

    logic [NUM_BANKS-1:0] bk_valid, bk_aband, bk_full, bk_empty;
    logic [NUM_BANKS-1:0] bk_push, bk_pop, bk_clear, bk_tag_wen, bk_fgr_wen;
    logic [NUM_BANKS-1:0] open_v, commit_v, aband_v, done_v;
    logic [NUM_BANKS-1:0] cmd_hit, req_hit, open_sel;
    fgr_t                 bk_fgr [NUM_BANKS];
    prf_t                 bk_pop_prf [NUM_BANKS];

    logic req_hit_any;
    logic alloc_fire;
    logic alloc_drop;
    logic abandon_start;
    logic drain_empty;
    logic tag_dup;
    prf_t drain_prf;

    // Tag matching, lowest free bank, drain mux
    always_comb begin
        open_sel  = '0;
        drain_prf = '0;
        tag_dup   = 1'b0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            cmd_hit[i] = bk_valid[i] && (bk_fgr[i] == fe_cmd.fgr);
            req_hit[i] = bk_valid[i] && !bk_aband[i] && (bk_fgr[i] == fe_req.fgr);
            if (!bk_valid[i]) begin
                open_sel    = '0;
                open_sel[i] = 1'b1;
            end
            if (drain_sel_q[i])
                drain_prf = drain_prf | bk_pop_prf[i];
            for (int j = 0; j < i; j++)
                tag_dup = tag_dup || (bk_valid[i] && bk_valid[j] && bk_fgr[i] == bk_fgr[j]);
        end
    end

    assign req_hit_any = |req_hit;
    assign drain_empty = |(drain_sel_q & bk_empty);

    // A speculative request needs room in its bank unless it is dropped
    assign fe_req_ready = (state_q == ST_RUN) && !fl_empty && core_rsp_ready &&
                          !(fe_req.spec && |(req_hit & bk_full));
    assign alloc_fire   = fe_req_valid && fe_req_ready;
    assign alloc_drop   = fe_req.spec && !req_hit_any;
    assign fl_ren       = alloc_fire && !alloc_drop;

    assign abandon_start = (state_q == ST_RUN) && fe_cmd_valid &&
                           (fe_cmd.op == GRP_ABANDON) && (|cmd_hit);
    assign fe_cmd_ready  = ((state_q == ST_RUN) && !abandon_start) ||
                           ((state_q == ST_DRAIN) && drain_empty);
    assign rel_ready     = (state_q == ST_RUN) && !fl_full;

    // Per-bank controls
    assign open_v   = {NUM_BANKS{fe_cmd_valid && fe_cmd_ready && fe_cmd.op == GRP_OPEN}}
                      & open_sel;
    assign commit_v = {NUM_BANKS{fe_cmd_valid && fe_cmd_ready && fe_cmd.op == GRP_COMMIT}}
                      & cmd_hit;
    assign aband_v  = {NUM_BANKS{abandon_start}} & cmd_hit;
    assign done_v   = {NUM_BANKS{state_q == ST_DRAIN}} & drain_sel_q & bk_empty;

    assign bk_tag_wen = open_v | commit_v | aband_v | done_v;
    assign bk_fgr_wen = open_v;
    assign bk_clear   = open_v | commit_v;
    assign bk_push    = {NUM_BANKS{fl_ren && fe_req.spec}} & req_hit;
    assign bk_pop     = {NUM_BANKS{state_q == ST_DRAIN}} & drain_sel_q & ~bk_empty;

    // Write port serves the fill, then a drain, then releases
    always_comb begin
        case (state_q)
            ST_FILL: begin
                fl_wen = 1'b1;
                fl_din = fill_prf_q;
            end
            ST_DRAIN: begin
                fl_wen = !drain_empty;
                fl_din = drain_prf;
            end
            default: begin
                fl_wen = rel_valid && rel_ready;
                fl_din = rel_prf;
            end
        endcase
    end

    common_fifo_ram_1w1r #(
        .DEPTH_LOG2 (PRF_W),
        .WIDTH      ($bits(prf_t))
    ) u_free_list (
        .clk   (clk),
        .rst   (rst),
        .clear (1'b0),
        .din   (fl_din),
        .wen   (fl_wen),
        .ren   (fl_ren),
        .dout  (fl_dout),
        .full  (fl_full),
        .empty (fl_empty)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        freelist_checkpoint_bank u_bank (
            .clk              (clk),
            .rst              (rst),
            .tag_wen          (bk_tag_wen[g]),
            .tag_valid_in     (open_v[g] || aband_v[g]),
            .tag_abandoned_in (aband_v[g]),
            .tag_valid        (bk_valid[g]),
            .tag_abandoned    (bk_aband[g]),
            .fgr_wen          (bk_fgr_wen[g]),
            .fgr_in           (fe_cmd.fgr),
            .fgr              (bk_fgr[g]),
            .fifo_clear       (bk_clear[g]),
            .push             (bk_push[g]),
            .push_prf         (fl_dout),
            .pop              (bk_pop[g]),
            .pop_prf          (bk_pop_prf[g]),
            .full             (bk_full[g]),
            .empty            (bk_empty[g])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q        <= ST_FILL;
            fill_prf_q     <= prf_t'(NUM_ARCH);
            drain_sel_q    <= '0;
            core_rsp_valid <= 1'b0;
        end else begin
            core_rsp_valid <= fl_ren;
            case (state_q)
                ST_FILL: begin
                    fill_prf_q <= fill_prf_q + 1'b1;
                    if (&fill_prf_q)
                        state_q <= ST_RUN;
                end
                ST_RUN: begin
                    if (abandon_start) begin
                        state_q     <= ST_DRAIN;
                        drain_sel_q <= cmd_hit;
                    end
                end
                ST_DRAIN: begin
                    if (drain_empty)
                        state_q <= ST_RUN;
                end
                default: state_q <= ST_FILL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fl_ren)
            core_rsp <= '{prf: fl_dout, fgr: fe_req.fgr};
    end

    a_tag_unique: assert property (@(posedge clk) disable iff (rst) !tag_dup)
        else $error("group tag open on two banks");
    // Upstream sent a speculative request for a group with no open bank
    a_alloc_known_group: assert property (@(posedge clk) disable iff (rst)
        !(alloc_fire && alloc_drop))
        else $error("speculative allocation for an unknown group was dropped");

endmodule

`default_nettype wire

// ==== verilog/prf_freelist_top.sv ====
/* Free list top: input side, core and response buffer.
   All readies stay low during the 32-cycle reset fill. */
`timescale 1ns/1ns
`default_nettype none

module prf_freelist_top #(
    parameter int NUM_BANKS = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  rename_chan_pkg::alloc_req_t req,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  rename_chan_pkg::group_cmd_t cmd,
    input  logic                        rel_valid,
    output logic                        rel_ready,
    input  rename_types_pkg::prf_t      rel_prf,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output rename_chan_pkg::alloc_rsp_t rsp
);

    import rename_chan_pkg::*;

    logic       fe_req_valid, fe_req_ready, fe_cmd_valid, fe_cmd_ready;
    logic       core_rsp_valid, core_rsp_ready;
    alloc_req_t fe_req;
    group_cmd_t fe_cmd;
    alloc_rsp_t core_rsp;

    rename_req_front u_front (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd          (cmd),
        .fe_req_valid (fe_req_valid),
        .fe_req_ready (fe_req_ready),
        .fe_req       (fe_req),
        .fe_cmd_valid (fe_cmd_valid),
        .fe_cmd_ready (fe_cmd_ready),
        .fe_cmd       (fe_cmd)
    );

    freelist_core #(
        .NUM_BANKS (NUM_BANKS)
    ) u_core (
        .clk            (clk),
        .rst            (rst),
        .fe_req_valid   (fe_req_valid),
        .fe_req_ready   (fe_req_ready),
        .fe_req         (fe_req),
        .fe_cmd_valid   (fe_cmd_valid),
        .fe_cmd_ready   (fe_cmd_ready),
        .fe_cmd         (fe_cmd),
        .rel_valid      (rel_valid),
        .rel_ready      (rel_ready),
        .rel_prf        (rel_prf),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .core_rsp       (core_rsp)
    );

    alloc_rsp_buffer u_rsp_buf (
        .clk            (clk),
        .rst            (rst),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .core_rsp       (core_rsp),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp)
    );

endmodule

`default_nettype wire

// ==== verilog/rename_chan_pkg.sv ====
/* Payload structs of the request, response and group command channels.
   Release carries a bare prf_t and has no struct. */
`default_nettype none

package rename_chan_pkg;

    // spec marks an allocation recorded in the group's checkpoint bank
    typedef struct packed {
        rename_types_pkg::fgr_t fgr;
        logic                   spec;
    } alloc_req_t;

    // Group tag is echoed back with the allocated register
    typedef struct packed {
        rename_types_pkg::prf_t prf;
        rename_types_pkg::fgr_t fgr;
    } alloc_rsp_t;

    typedef struct packed {
        rename_types_pkg::group_op_t op;
        rename_types_pkg::fgr_t      fgr;
    } group_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/rename_req_front.sv ====
/* Input side: two-entry buffer for allocation requests and one command slot.
   A pending command is offered alone; upstream readies come from registers. */
`timescale 1ns/1ns
`default_nettype none

module rename_req_front (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  rename_chan_pkg::alloc_req_t req,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  rename_chan_pkg::group_cmd_t cmd,
    output logic                        fe_req_valid,
    input  logic                        fe_req_ready,
    output rename_chan_pkg::alloc_req_t fe_req,
    output logic                        fe_cmd_valid,
    input  logic                        fe_cmd_ready,
    output rename_chan_pkg::group_cmd_t fe_cmd
);

    import rename_chan_pkg::*;

    // Set once the core has finished its reset fill
    logic       up_q;
    logic [1:0] req_cnt_q;
    alloc_req_t slot1_q;
    logic       req_push;
    logic       req_pop;

    assign req_ready    = up_q && (req_cnt_q != 2'd2);
    assign cmd_ready    = up_q && !fe_cmd_valid;
    assign fe_req_valid = (req_cnt_q != 2'd0) && !fe_cmd_valid;

    assign req_push = req_valid && req_ready;
    assign req_pop  = fe_req_valid && fe_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            up_q         <= 1'b0;
            req_cnt_q    <= 2'd0;
            fe_cmd_valid <= 1'b0;
        end else begin
            up_q      <= up_q || fe_cmd_ready;
            req_cnt_q <= req_cnt_q + 2'(req_push) - 2'(req_pop);
            if (cmd_valid && cmd_ready)
                fe_cmd_valid <= 1'b1;
            else if (fe_cmd_ready)
                fe_cmd_valid <= 1'b0;
        end
    end

    // fe_req is the head slot, slot1_q the one behind it
    always_ff @(posedge clk) begin
        if (req_push && (req_cnt_q == 2'd0 || (req_cnt_q == 2'd1 && req_pop)))
            fe_req <= req;
        else if (req_pop)
            fe_req <= slot1_q;
        if (req_push)
            slot1_q <= req;
        if (cmd_valid && cmd_ready)
            fe_cmd <= cmd;
    end

endmodule

`default_nettype wire

// ==== verilog/rename_types_pkg.sv ====
/* Register, group tag and bank index widths for the renamer free list.
   64 physical registers; the first NUM_ARCH hold architectural state after reset. */
`default_nettype none

package rename_types_pkg;

    localparam int PRF_W      = 6;
    localparam int FGR_W      = 4;
    localparam int BANK_IDX_W = 2;

    // Registers 0 .. NUM_ARCH-1 are never in the free list after reset
    localparam int NUM_ARCH   = 32;

    typedef logic [PRF_W-1:0]      prf_t;
    typedef logic [FGR_W-1:0]      fgr_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;

    typedef enum logic [1:0] {
        GRP_OPEN,
        GRP_COMMIT,
        GRP_ABANDON
    } group_op_t;

endpackage

`default_nettype wire
